/* source/exec_pkg.sv */
`default_nettype none

package exec_pkg;

	localparam int XLEN = 32;
	localparam int SEL_W = 4;
	localparam int LINK_STEP = 4;

	typedef logic [XLEN-1:0] word_t;

	typedef enum logic [5:0] {
		OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
		OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
		OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI,
		OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
		OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
		OP_SB, OP_SH, OP_SW,
		OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
		OP_JAL, OP_JALR, OP_LUI, OP_AUIPC
	} exec_op_e;

	typedef enum logic [2:0] {
		CLS_ALU, CLS_BRANCH, CLS_JUMP, CLS_LOAD, CLS_STORE, CLS_UPPER
	} op_class_e;

	typedef struct packed {
		exec_op_e op;
		word_t rs1;
		word_t rs2;
		word_t imm;
		word_t pc;
	} exec_issue_t;

	typedef struct packed {
		logic rd_we;
		word_t rd_data;
		logic jump_taken;
		word_t jump_target;
	} exec_result_t;

	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		word_t adr;
		logic [SEL_W-1:0] sel;
		word_t dat;
	} wb_m2s_t;

	typedef struct packed {
		logic ack;
		word_t dat;
	} wb_s2m_t;

	// same bus word, byte lanes or halfword lanes
	typedef union packed {
		logic [3:0][7:0] b;
		logic [1:0][15:0] h;
	} mem_word_u;

	function automatic op_class_e op_class(exec_op_e op);
		case (op)
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: return CLS_LOAD;
			OP_SB, OP_SH, OP_SW: return CLS_STORE;
			OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: return CLS_BRANCH;
			OP_JAL, OP_JALR: return CLS_JUMP;
			OP_LUI, OP_AUIPC: return CLS_UPPER;
			default: return CLS_ALU; // register and immediate forms
		endcase
	endfunction

endpackage

`default_nettype wire

/* source/exec_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_alu import exec_pkg::*; (
	input  exec_op_e op,
	input  word_t    rs1,
	input  word_t    rs2,
	input  word_t    imm,
	output word_t    y
);

	logic use_imm;
	word_t opb;
	logic [4:0] shamt;

	always_comb begin
		case (op)
			OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI,
			OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI: use_imm = 1'b1;
			default: use_imm = 1'b0;
		endcase
	end

	assign opb = use_imm ? imm : rs2;
	assign shamt = opb[4:0]; // low five bits only

	always_comb begin
		case (op)
			OP_ADD, OP_ADDI: y = rs1 + opb;
			OP_SUB: y = rs1 - opb;
			OP_SLL, OP_SLLI: y = rs1 << shamt;
			OP_SLT, OP_SLTI: begin
				y = {{(XLEN-1){1'b0}}, $signed(rs1) < $signed(opb)};
			end
			OP_SLTU, OP_SLTIU: begin
				y = {{(XLEN-1){1'b0}}, rs1 < opb};
			end
			OP_XOR, OP_XORI: y = rs1 ^ opb;
			OP_SRL, OP_SRLI: y = rs1 >> shamt;
			OP_SRA, OP_SRAI: y = word_t'($signed(rs1) >>> shamt);
			OP_OR, OP_ORI: y = rs1 | opb;
			OP_AND, OP_ANDI: y = rs1 & opb;
			default: y = '0; // not an alu op
		endcase
	end

endmodule

`default_nettype wire

/* source/branch_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_unit import exec_pkg::*; (
	input  exec_op_e op,
	input  word_t    rs1,
	input  word_t    rs2,
	input  word_t    imm,
	input  word_t    pc,
	output logic     taken,
	output word_t    target,
	output word_t    link
);

	logic eq;
	logic lt_s;
	logic lt_u;
	word_t reg_target;

	assign eq = rs1 == rs2;
	assign lt_s = $signed(rs1) < $signed(rs2);
	assign lt_u = rs1 < rs2;

	always_comb begin
		case (op)
			OP_BEQ: taken = eq;
			OP_BNE: taken = !eq;
			OP_BLT: taken = lt_s;
			OP_BGE: taken = !lt_s;
			OP_BLTU: taken = lt_u;
			OP_BGEU: taken = !lt_u;
			OP_JAL, OP_JALR: taken = 1'b1; // unconditional
			default: taken = 1'b0;
		endcase
	end

	assign reg_target = rs1 + imm;

	// jalr drops bit 0 of the sum
	assign target = (op == OP_JALR) ? {reg_target[XLEN-1:1], 1'b0} : pc + imm;
	assign link = pc + word_t'(LINK_STEP);

endmodule

`default_nettype wire

/* source/lsu_wb.sv */
`timescale 1ns/1ps
`default_nettype none

module lsu_wb import exec_pkg::*; (
	input  logic     clk,
	input  logic     rst,
	input  logic     start,
	input  exec_op_e op,
	input  word_t    rs1,
	input  word_t    rs2,
	input  word_t    imm,
	output logic     done,
	output word_t    load_data,
	output wb_m2s_t  wb_m,
	input  wb_s2m_t  wb_s
);

	word_t addr;
	logic [SEL_W-1:0] sel_d;
	word_t dat_d;

	logic cyc_q;
	logic we_q;
	word_t adr_q;
	logic [SEL_W-1:0] sel_q;
	word_t dat_q;
	logic [1:0] ofs_q;
	exec_op_e op_q;

	mem_word_u rdat;

	assign addr = rs1 + imm;

	// lanes touched and replicated store data
	always_comb begin
		case (op)
			OP_LB, OP_LBU, OP_SB: begin
				sel_d = 4'b0001 << addr[1:0];
				dat_d = {4{rs2[7:0]}};
			end
			OP_LH, OP_LHU, OP_SH: begin
				sel_d = addr[1] ? 4'b1100 : 4'b0011;
				dat_d = {2{rs2[15:0]}};
			end
			default: begin
				sel_d = {SEL_W{1'b1}};
				dat_d = rs2;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cyc_q <= 1'b0;
			we_q <= 1'b0;
		end else if (start) begin
			cyc_q <= 1'b1;
			we_q <= op_class(op) == CLS_STORE;
		end else if (done) begin
			cyc_q <= 1'b0; // drop after ack
			we_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			adr_q <= {addr[XLEN-1:2], 2'b00};
			sel_q <= sel_d;
			dat_q <= dat_d;
			ofs_q <= addr[1:0]; // kept for the returning lane
			op_q <= op;
		end
	end

	assign wb_m = '{cyc: cyc_q, stb: cyc_q, we: we_q, adr: adr_q, sel: sel_q, dat: dat_q};
	assign done = cyc_q & wb_s.ack;

	assign rdat = wb_s.dat;

	always_comb begin
		case (op_q)
			OP_LB: load_data = {{(XLEN-8){rdat.b[ofs_q][7]}}, rdat.b[ofs_q]};
			OP_LBU: load_data = {{(XLEN-8){1'b0}}, rdat.b[ofs_q]};
			OP_LH: load_data = {{(XLEN-16){rdat.h[ofs_q[1]][15]}}, rdat.h[ofs_q[1]]};
			OP_LHU: load_data = {{(XLEN-16){1'b0}}, rdat.h[ofs_q[1]]};
			default: load_data = rdat; // lw
		endcase
	end

endmodule

`default_nettype wire

/* source/exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit import exec_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         issue_valid,
	output logic         issue_ready,
	input  exec_issue_t  issue,
	output logic         result_valid,
	output exec_result_t result,
	output wb_m2s_t      wb_m,
	input  wb_s2m_t      wb_s
);

	op_class_e cls;
	logic accept;
	logic is_mem;
	logic mem_busy;
	logic mem_load_q;

	word_t alu_y;
	logic br_taken;
	word_t br_target;
	word_t br_link;
	logic lsu_done;
	word_t lsu_data;

	exec_result_t nxt;

	assign cls = op_class(issue.op);
	assign is_mem = (cls == CLS_LOAD) || (cls == CLS_STORE);
	assign issue_ready = !mem_busy;
	assign accept = issue_valid && issue_ready;

	exec_alu exec_alu_inst (
		.op  (issue.op),
		.rs1 (issue.rs1),
		.rs2 (issue.rs2),
		.imm (issue.imm),
		.y   (alu_y)
	);

	branch_unit branch_unit_inst (
		.op     (issue.op),
		.rs1    (issue.rs1),
		.rs2    (issue.rs2),
		.imm    (issue.imm),
		.pc     (issue.pc),
		.taken  (br_taken),
		.target (br_target),
		.link   (br_link)
	);

	lsu_wb lsu_wb_inst (
		.clk       (clk),
		.rst       (rst),
		.start     (accept && is_mem),
		.op        (issue.op),
		.rs1       (issue.rs1),
		.rs2       (issue.rs2),
		.imm       (issue.imm),
		.done      (lsu_done),
		.load_data (lsu_data),
		.wb_m      (wb_m),
		.wb_s      (wb_s)
	);

	// single-cycle result paths
	always_comb begin
		nxt.rd_we = 1'b0;
		nxt.rd_data = '0;
		nxt.jump_taken = 1'b0;
		nxt.jump_target = br_target;
		case (cls)
			CLS_ALU: begin
				nxt.rd_we = 1'b1;
				nxt.rd_data = alu_y;
			end
			CLS_BRANCH: nxt.jump_taken = br_taken;
			CLS_JUMP: begin
				nxt.rd_we = 1'b1;
				nxt.rd_data = br_link;
				nxt.jump_taken = br_taken;
			end
			CLS_UPPER: begin
				nxt.rd_we = 1'b1;
				nxt.rd_data = (issue.op == OP_LUI) ? issue.imm : issue.pc + issue.imm;
			end
			default: nxt.rd_we = 1'b0; // memory ops finish later
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			mem_busy <= 1'b0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= (accept && !is_mem) || lsu_done;
			if (accept && is_mem)
				mem_busy <= 1'b1;
			else if (lsu_done)
				mem_busy <= 1'b0; // ready again in the result cycle
		end
	end

	always_ff @(posedge clk) begin
		if (accept && is_mem)
			mem_load_q <= cls == CLS_LOAD;
		if (accept && !is_mem) begin
			result <= nxt;
		end else if (lsu_done) begin
			result.rd_we <= mem_load_q;
			result.rd_data <= mem_load_q ? lsu_data : '0;
			result.jump_taken <= 1'b0;
			result.jump_target <= '0;
		end
	end

endmodule

`default_nettype wire

/* sim/wb_ram_model.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_ram_model import exec_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  logic [3:0] ack_delay,
	input  wb_m2s_t    wb_m,
	output wb_s2m_t    wb_s
);

	word_t mem [0:255];
	word_t merged;
	logic [3:0] wait_cnt;
	logic [7:0] idx;
	logic ack_now;

	assign idx = wb_m.adr[9:2];
	assign ack_now = wb_m.cyc && wb_m.stb && (wait_cnt == ack_delay); // delay 0 acks at once
	assign wb_s = '{ack: ack_now, dat: mem[idx]};

	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = {i[7:0], ~i[7:0], i[7:0] ^ 8'h5a, 8'hc3 ^ i[7:0]};
	end

	always @(posedge clk) begin
		if (rst || !(wb_m.cyc && wb_m.stb) || ack_now)
			wait_cnt <= '0;
		else
			wait_cnt <= wait_cnt + 4'd1;
		if (ack_now && wb_m.we) begin
			merged = mem[idx];
			for (int k = 0; k < SEL_W; k++)
				if (wb_m.sel[k])
					merged[k*8 +: 8] = wb_m.dat[k*8 +: 8]; // selected lanes only
			mem[idx] <= merged;
		end
	end

endmodule

`default_nettype wire

/* sim/exec_unit_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_unit_chk import exec_pkg::*; (
	input logic    clk,
	input logic    rst,
	input logic    issue_valid,
	input logic    issue_ready,
	input logic    result_valid,
	input wb_m2s_t wb_m,
	input wb_s2m_t wb_s
);

	cyc_matches_stb: assert property (@(posedge clk) disable iff (rst) wb_m.cyc == wb_m.stb)
		else $error("wishbone cyc and stb differ");

	master_held: assert property (@(posedge clk) disable iff (rst)
		wb_m.cyc && !wb_s.ack |=> $stable(wb_m))
		else $error("master signals changed before ack");

	ack_needs_cyc: assert property (@(posedge clk) disable iff (rst) wb_s.ack |-> wb_m.cyc)
		else $error("ack seen without cyc");

	// memory result comes only after the bus cycle and lasts one cycle
	no_result_in_bus_cycle: assert property (@(posedge clk) disable iff (rst)
		wb_m.cyc |-> !result_valid)
		else $error("result_valid high during a bus cycle");

	// an op accepted in the result cycle may legally follow at once
	single_mem_result: assert property (@(posedge clk) disable iff (rst)
		result_valid && $past(wb_m.cyc) && !(issue_valid && issue_ready) |=> !result_valid)
		else $error("memory result_valid held for two cycles");

endmodule

bind exec_unit exec_unit_chk exec_unit_chk_inst (
	.clk          (clk),
	.rst          (rst),
	.issue_valid  (issue_valid),
	.issue_ready  (issue_ready),
	.result_valid (result_valid),
	.wb_m         (wb_m),
	.wb_s         (wb_s)
);

`default_nettype wire

/* sim/tb_exec_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_unit import exec_pkg::*; ();

	logic clk = 1'b0;
	logic rst;
	logic issue_valid;
	logic issue_ready;
	exec_issue_t issue;
	logic result_valid;
	exec_result_t result;
	wb_m2s_t wb_m;
	wb_s2m_t wb_s;
	logic [3:0] ack_delay;

	int seed = 20;
	int timeout_cycles = 40;
	int check_count = 0;
	int mismatch_count = 0;
	int other_errors = 0;
	logic aborted = 1'b0;
	logic [7:0] shadow [0:1023]; // expected memory bytes

	always #4 clk = ~clk;

	exec_unit exec_unit_inst (
		.clk          (clk),
		.rst          (rst),
		.issue_valid  (issue_valid),
		.issue_ready  (issue_ready),
		.issue        (issue),
		.result_valid (result_valid),
		.result       (result),
		.wb_m         (wb_m),
		.wb_s         (wb_s)
	);

	wb_ram_model wb_ram_model_inst (
		.clk       (clk),
		.rst       (rst),
		.ack_delay (ack_delay),
		.wb_m      (wb_m),
		.wb_s      (wb_s)
	);

	task automatic check_val(input string name, input word_t got, input word_t exp);
		check_count++;
		if (got !== exp) begin
			mismatch_count++;
			$display("Mismatch at %0d ns: %s got %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic report_timeout(input string what);
		other_errors++;
		aborted = 1'b1;
		$display("Timeout at %0d ns: %s", $time, what);
	endtask

	function automatic logic signed_less(word_t a, word_t b);
		return (a[31] != b[31]) ? a[31] : (a < b); // sign bits decide first
	endfunction

	function automatic word_t alu_expect(exec_op_e op, word_t a, word_t r2, word_t im);
		word_t b;
		logic [4:0] sh;
		b = (op inside {OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
			OP_SLLI, OP_SRLI, OP_SRAI}) ? im : r2;
		sh = b[4:0];
		case (op)
			OP_ADD, OP_ADDI: return a + b;
			OP_SUB: return a - b;
			OP_SLL, OP_SLLI: return a << sh;
			OP_SLT, OP_SLTI: return {31'd0, signed_less(a, b)};
			OP_SLTU, OP_SLTIU: return {31'd0, a < b};
			OP_XOR, OP_XORI: return a ^ b;
			OP_SRL, OP_SRLI: return a >> sh;
			OP_SRA, OP_SRAI: return a[31] ? ~(~a >> sh) : a >> sh;
			OP_OR, OP_ORI: return a | b;
			OP_AND, OP_ANDI: return a & b;
			default: return 32'd0;
		endcase
	endfunction

	function automatic logic branch_expect(exec_op_e op, word_t a, word_t b);
		case (op)
			OP_BEQ: return a == b;
			OP_BNE: return a != b;
			OP_BLT: return signed_less(a, b);
			OP_BGE: return !signed_less(a, b);
			OP_BLTU: return a < b;
			OP_BGEU: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	// issue one op, wait for acceptance and result, compare
	task automatic exec_and_check(input exec_op_e op, input word_t rs1, input word_t rs2,
			input word_t imm, input word_t pc, input exec_result_t exp);
		logic mem_op;
		int waited;
		int lat;
		exec_result_t got;
		if (aborted)
			return;
		mem_op = op inside {OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW};
		@(posedge clk);
		issue_valid <= 1'b1;
		issue <= '{op: op, rs1: rs1, rs2: rs2, imm: imm, pc: pc};
		waited = 0;
		@(negedge clk);
		while (!issue_ready && waited < timeout_cycles) begin
			@(negedge clk);
			waited++;
		end
		if (!issue_ready) begin
			report_timeout({op.name(), ": issue_ready never rose"});
			return;
		end
		@(posedge clk); // accept edge
		issue_valid <= 1'b0;
		lat = 1;
		@(negedge clk);
		while (!result_valid && lat < timeout_cycles) begin
			if (mem_op)
				check_val({op.name(), " issue_ready"}, word_t'(issue_ready), 32'd0);
			@(negedge clk);
			lat++;
		end
		if (!result_valid) begin
			report_timeout({op.name(), ": result_valid never rose"});
			return;
		end
		got = result;
		check_val({op.name(), " latency"}, lat, mem_op ? {28'd0, ack_delay} + 32'd2 : 32'd1);
		check_val({op.name(), " rd_we"}, word_t'(got.rd_we), word_t'(exp.rd_we));
		if (exp.rd_we)
			check_val({op.name(), " rd_data"}, got.rd_data, exp.rd_data);
		check_val({op.name(), " jump_taken"}, word_t'(got.jump_taken), word_t'(exp.jump_taken));
		if (exp.jump_taken)
			check_val({op.name(), " jump_target"}, got.jump_target, exp.jump_target);
	endtask

	task automatic check_reset_state();
		@(negedge clk);
		check_val("result_valid", word_t'(result_valid), 32'd0);
		check_val("wb_m.cyc", word_t'(wb_m.cyc), 32'd0);
		check_val("wb_m.stb", word_t'(wb_m.stb), 32'd0);
		check_val("wb_m.we", word_t'(wb_m.we), 32'd0);
		check_val("issue_ready", word_t'(issue_ready), 32'd1);
	endtask

	task automatic test_alu_ops();
		exec_op_e ops [19] = '{OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL,
			OP_SRA, OP_OR, OP_AND, OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
			OP_SLLI, OP_SRLI, OP_SRAI};
		word_t edge_a [4] = '{32'h8000_0000, 32'hffff_ffff, 32'h7fff_ffff, 32'h8765_4321};
		word_t edge_b [4] = '{32'hffff_ffff, 32'h8000_0000, 32'd0, 32'd31};
		word_t a;
		word_t b;
		word_t c;
		exec_result_t exp;
		foreach (ops[i]) begin
			for (int k = 0; k < 8; k++) begin
				a = (k < 4) ? edge_a[k] : $random(seed);
				b = (k < 4) ? edge_b[k] : $random(seed);
				c = (k < 4) ? edge_b[k] : $random(seed); // imm differs on random rows
				exp = '{rd_we: 1'b1, rd_data: alu_expect(ops[i], a, b, c),
					jump_taken: 1'b0, jump_target: 32'd0};
				exec_and_check(ops[i], a, b, c, 32'h0000_0100, exp);
			end
		end
	endtask

	task automatic test_branches();
		exec_op_e ops [6] = '{OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
		word_t pair_a [6] = '{32'd1, 32'd2, 32'hffff_ffff, 32'd1, 32'd5, 32'h8000_0000};
		word_t pair_b [6] = '{32'd2, 32'd1, 32'd1, 32'hffff_ffff, 32'd5, 32'h7fff_ffff};
		word_t r;
		word_t imm;
		word_t pc;
		exec_result_t exp;
		foreach (ops[i]) begin
			foreach (pair_a[k]) begin
				r = $random(seed);
				imm = {{19{r[12]}}, r[12:1], 1'b0}; // 13-bit branch offset
				pc = r & 32'h000f_fffc;
				exp = '{rd_we: 1'b0, rd_data: 32'd0,
					jump_taken: branch_expect(ops[i], pair_a[k], pair_b[k]),
					jump_target: pc + imm};
				exec_and_check(ops[i], pair_a[k], pair_b[k], imm, pc, exp);
			end
		end
	endtask

	task automatic check_jump(input exec_op_e op, input word_t rs1, input word_t imm,
			input word_t pc);
		exec_result_t exp;
		exp = '{rd_we: 1'b1, rd_data: pc + 32'd4, jump_taken: 1'b1,
			jump_target: (op == OP_JALR) ? (rs1 + imm) & 32'hffff_fffe : pc + imm};
		exec_and_check(op, rs1, $random(seed), imm, pc, exp);
	endtask

	task automatic check_upper(input exec_op_e op, input word_t imm, input word_t pc);
		exec_result_t exp;
		exp = '{rd_we: 1'b1, rd_data: (op == OP_LUI) ? imm : pc + imm,
			jump_taken: 1'b0, jump_target: 32'd0};
		exec_and_check(op, $random(seed), $random(seed), imm, pc, exp);
	endtask

	task automatic mem_store(input exec_op_e op, input word_t addr, input word_t data);
		int nbytes;
		exec_result_t exp;
		nbytes = (op == OP_SB) ? 1 : (op == OP_SH) ? 2 : 4;
		for (int k = 0; k < nbytes; k++)
			shadow[addr[9:0] + 10'(k)] = data[k*8 +: 8]; // little endian
		exp = '{rd_we: 1'b0, rd_data: 32'd0, jump_taken: 1'b0, jump_target: 32'd0};
		exec_and_check(op, addr + 32'h10, data, 32'hffff_fff0, 32'h0000_0400, exp);
	endtask

	task automatic mem_load(input exec_op_e op, input word_t addr);
		logic [9:0] a;
		word_t raw;
		word_t val;
		exec_result_t exp;
		a = addr[9:0];
		raw = {shadow[a + 10'd3], shadow[a + 10'd2], shadow[a + 10'd1], shadow[a]};
		case (op)
			OP_LB: val = {{24{raw[7]}}, raw[7:0]};
			OP_LBU: val = {24'd0, raw[7:0]};
			OP_LH: val = {{16{raw[15]}}, raw[15:0]};
			OP_LHU: val = {16'd0, raw[15:0]};
			default: val = raw;
		endcase
		exp = '{rd_we: 1'b1, rd_data: val, jump_taken: 1'b0, jump_target: 32'd0};
		exec_and_check(op, addr + 32'h8, $random(seed), 32'hffff_fff8, 32'h0000_0500, exp);
	endtask

	task automatic test_loads_stores(input logic [3:0] delay);
		word_t base;
		@(posedge clk);
		ack_delay <= delay;
		base = (delay == 4'd0) ? 32'h0000_0100 : 32'h0000_0200;
		mem_store(OP_SW, base, 32'h8899_aabb);
		mem_store(OP_SB, base + 32'd1, 32'h0000_00e5); // one lane inside a full word
		mem_store(OP_SB, base + 32'd4, 32'h1234_5681);
		mem_store(OP_SB, base + 32'd5, 32'h0000_0012);
		mem_store(OP_SB, base + 32'd6, 32'hffff_fff3);
		mem_store(OP_SB, base + 32'd7, 32'h0000_7f44);
		mem_store(OP_SH, base + 32'd8, 32'h0000_8001);
		mem_store(OP_SH, base + 32'd10, 32'h1234_7ffe);
		for (int k = 0; k < 12; k++) begin
			mem_load(OP_LB, base + word_t'(k));
			mem_load(OP_LBU, base + word_t'(k));
			if (k % 2 == 0) begin
				mem_load(OP_LH, base + word_t'(k));
				mem_load(OP_LHU, base + word_t'(k));
			end
			if (k % 4 == 0)
				mem_load(OP_LW, base + word_t'(k));
		end
	endtask

	task automatic finish_run();
		$display("checks: %0d, mismatches: %0d, other errors: %0d",
			check_count, mismatch_count, other_errors);
		if (mismatch_count == 0 && other_errors == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	endtask

	initial begin
		rst = 1'b1;
		issue_valid = 1'b0;
		issue = '0;
		ack_delay = 4'd0;
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		check_reset_state();
		test_alu_ops();
		test_branches();
		check_jump(OP_JAL, 32'h1111_1111, 32'h0000_0040, 32'h0000_0100);
		check_jump(OP_JAL, 32'h1111_1111, 32'hffff_fff0, 32'h0000_0800);
		check_jump(OP_JALR, 32'h0000_2001, 32'h0000_0010, 32'h0000_0300); // odd sum
		check_jump(OP_JALR, 32'h0000_1000, 32'hffff_ffff, 32'h0000_0304);
		check_upper(OP_LUI, 32'hdead_b000, 32'h0000_0600);
		check_upper(OP_AUIPC, 32'hffff_f000, 32'h0000_1230);
		check_upper(OP_AUIPC, 32'h0001_2000, 32'h0000_0ffc);
		test_loads_stores(4'd0);
		test_loads_stores(4'd3);
		finish_run();
	end

endmodule

`default_nettype wire

/* build.f */
source/exec_pkg.sv
source/exec_alu.sv
source/branch_unit.sv
source/lsu_wb.sv
source/exec_unit.sv
sim/wb_ram_model.sv
sim/exec_unit_chk.sv
sim/tb_exec_unit.sv

/* Makefile */
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP ?= tb_exec_unit
FILELIST ?= build.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= Test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, fail unless the pass line appears"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
